/* vlog.f */
+incdir+logic
logic/lsu_op_pkg.sv
logic/lsu_bus_pkg.sv
logic/lsu_addr_gen.sv
logic/lsu_ctrl.sv
logic/lsu_rdata_align.sv
logic/lsu_top.sv
verif/tb_clkgen.sv
verif/lsu_properties.sv
verif/tb_lsu.sv

/* verif/tb_lsu.sv */
//////////////////////////////
// Testbench for the load/store unit
// Bus memory model with random grant and response delays,
// golden byte memory, directed and random loads and stores
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "lsu_params.svh"

module tb_lsu;

  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;

  localparam int          RST_CYCLES     = 10;
  localparam logic [31:0] LFSR_SEED      = 32'h27b729e6;
  localparam int          N_RANDOM       = 200;
  // Word 2, bytes 12, halfwords 12, split words 6, errors 3
  localparam int          N_DIRECTED     = 35;
  localparam int          N_OPS          = N_DIRECTED + N_RANDOM;
  localparam int          TIMEOUT_CYCLES = 12 * N_OPS;
  // Word of the bus memory that answers with an error
  localparam int          ERR_WORD       = 63;

  logic        clk;
  logic        rst_n;
  logic        ex_valid_i;
  lsu_word_t   operand_a_i;
  lsu_word_t   operand_b_i;
  lsu_word_t   wdata_i;
  logic        we_i;
  lsu_size_e   size_i;
  logic        sext_i;
  logic        ex_ready_o;
  logic        split_o;
  logic        first_op_o;
  logic        last_op_o;
  logic        data_req_o;
  logic        data_gnt_i = 1'b0;
  lsu_word_t   data_addr_o;
  logic        data_we_o;
  lsu_be_t     data_be_o;
  lsu_word_t   data_wdata_o;
  logic        data_rvalid_i = 1'b0;
  lsu_word_t   data_rdata_i = '0;
  logic        data_err_i = 1'b0;
  logic        wb_valid_o;
  lsu_word_t   wb_rdata_o;
  logic        wb_err_o;
  logic        busy_o;
  logic        interruptible_o;
  logic        protocol_err_o;

  logic [31:0] lfsr_q = LFSR_SEED;
  int          cyc = 0;
  lsu_word_t   mem [64];
  logic [7:0]  gold [256];

  // Bus model state
  int          gnt_wait = 0;
  int          gnt_delay = 0;
  int          outstanding = 0;
  logic        stray_pending = 1'b0;
  lsu_word_t   resp_data_q [$];
  logic        resp_err_q [$];
  int          resp_due_q [$];

  // Expected bus transfers, one entry per phase
  lsu_word_t   exp_addr_q [$];
  lsu_be_t     exp_be_q [$];
  logic        exp_split_q [$];
  logic        exp_first_q [$];
  logic        exp_we_q [$];
  // Expected writebacks, one entry per access
  logic        exp_ld_q [$];
  lsu_word_t   exp_data_q [$];
  logic        exp_err_q [$];

  tb_clkgen #(.PERIOD(8), .RST_CYCLES(RST_CYCLES)) clkgen0 (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  lsu_top dut0 (.*);

  ////////////////////////////// Helpers
  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_word(input string name, input lsu_word_t got, input lsu_word_t exp);
    if (got !== exp) begin
      fail_stop($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_be(input string name, input lsu_be_t got, input lsu_be_t exp);
    if (got !== exp) begin
      fail_stop($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_stop($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Initial memory contents, different for every word
  function automatic lsu_word_t fill_word(input int idx);
    return 32'hA5C3_0000 ^ (idx * 32'h0103_0507);
  endfunction

  function automatic int size_bytes(input lsu_size_e size);
    case (size)
      SIZE_BYTE: return 1;
      SIZE_HALF: return 2;
      default:   return 4;
    endcase
  endfunction

  ////////////////////////////// Reference model
  // Little-endian gather from the golden memory, then extension
  function automatic lsu_word_t load_ref(input lsu_word_t addr, input lsu_size_e size,
                                         input logic sext);
    lsu_word_t raw;
    raw = '0;
    for (int i = 0; i < 4; i++) begin
      raw[8*i +: 8] = gold[8'(addr + i)];
    end
    case (size)
      SIZE_BYTE: return sext ? lsu_word_t'($signed(raw[7:0])) : lsu_word_t'(raw[7:0]);
      SIZE_HALF: return sext ? lsu_word_t'($signed(raw[15:0])) : lsu_word_t'(raw[15:0]);
      default:   return raw;
    endcase
  endfunction

  // Any byte of the access inside the error word
  function automatic logic err_ref(input lsu_word_t addr, input int nb);
    logic e;
    e = 1'b0;
    for (int i = 0; i < nb; i++) begin
      if (8'(addr + i) >= 8'(4 * ERR_WORD)) e = 1'b1;
    end
    return e;
  endfunction

  ////////////////////////////// Bus memory model
  // Accept transfers and count outstanding ones on the rising edge
  always @(posedge clk) begin : bus_accept
    int   idx;
    logic acc;
    logic rsp;
    logic exp_split;
    if (rst_n) begin
      acc = data_req_o && data_gnt_i;
      rsp = data_rvalid_i && (outstanding != 0);
      // Interruptible only with nothing in flight and no stalled request
      check_flag("interruptible_o", interruptible_o, outstanding == 0 && gnt_wait == 0);
      check_flag("protocol_err_o", protocol_err_o, data_rvalid_i && outstanding == 0);
      if (acc && exp_addr_q.size() == 0) begin
        fail_stop("bus request seen with no access in progress");
      end else begin
        if (acc) begin
          exp_split = exp_split_q.pop_front();
          check_word("data_addr_o", data_addr_o, exp_addr_q.pop_front());
          check_be("data_be_o", data_be_o, exp_be_q.pop_front());
          check_flag("split_o", split_o, exp_split);
          check_flag("first_op_o", first_op_o, exp_first_q.pop_front());
          check_flag("last_op_o", last_op_o, !exp_split);
          check_flag("data_we_o", data_we_o, exp_we_q.pop_front());
          idx = data_addr_o[7:2];
          if (data_we_o) begin
            for (int l = 0; l < `LSU_NBYTES; l++) begin
              if (data_be_o[l]) mem[idx][8*l +: 8] = data_wdata_o[8*l +: 8];
            end
          end
          // In-order response 1 to 3 cycles later
          resp_data_q.push_back(mem[idx]);
          resp_err_q.push_back(idx == ERR_WORD);
          resp_due_q.push_back(cyc + 1 + int'(rand_bits(2) % 3));
          gnt_wait  = 0;
          gnt_delay = int'(rand_bits(2) % 3);
        end else if (data_req_o) begin
          gnt_wait++;
        end
        outstanding = outstanding + int'(acc) - int'(rsp);
        if (outstanding > `LSU_DEPTH) begin
          fail_stop("more than two bus transfers outstanding");
        end
      end
    end
  end

  // Grant and response driven on the falling edge
  always @(negedge clk) begin
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    if (resp_due_q.size() != 0 && cyc >= resp_due_q[0]) begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = resp_data_q.pop_front();
      data_err_i    = resp_err_q.pop_front();
      void'(resp_due_q.pop_front());
    end else if (stray_pending) begin
      // Response nobody asked for
      data_rvalid_i = 1'b1;
      stray_pending = 1'b0;
    end
    data_gnt_i = (gnt_wait >= gnt_delay);
  end

  ////////////////////////////// Writeback compare
  always @(posedge clk) begin
    if (rst_n && wb_valid_o) begin
      if (exp_ld_q.size() == 0) begin
        fail_stop("writeback seen with no access pending");
      end else begin
        check_flag("wb_err_o", wb_err_o, exp_err_q.pop_front());
        if (exp_ld_q.pop_front()) begin
          check_word("wb_rdata_o", wb_rdata_o, exp_data_q.pop_front());
        end else begin
          void'(exp_data_q.pop_front());
        end
      end
    end
  end

  // Run length limit and bound assertion watch
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > TIMEOUT_CYCLES) begin
      fail_stop($sformatf("run timed out after %0d cycles", cyc));
    end else if (dut0.u_props.fail_cnt != 0) begin
      fail_stop("a bound bus or handshake assertion failed");
    end
  end

  ////////////////////////////// Stimulus
  // One access, held until the execute handshake completes
  task automatic run_op(input logic we, input lsu_size_e size, input logic sext,
                        input lsu_word_t addr, input lsu_word_t wdata);
    lsu_word_t b;
    lsu_be_t   be_lo;
    lsu_be_t   be_hi;
    int        nb;
    int        lane;
    @(negedge clk);
    b     = rand_bits(12);
    nb    = size_bytes(size);
    be_lo = '0;
    be_hi = '0;
    // Lanes past lane 3 belong to the next word
    for (int i = 0; i < nb; i++) begin
      lane = int'(addr[1:0]) + i;
      if (lane < 4) be_lo[lane] = 1'b1;
      else be_hi[lane - 4] = 1'b1;
    end
    exp_addr_q.push_back(addr);
    exp_be_q.push_back(be_lo);
    exp_split_q.push_back(be_hi != '0);
    exp_first_q.push_back(1'b1);
    exp_we_q.push_back(we);
    if (be_hi != '0) begin
      exp_addr_q.push_back({addr[31:2], 2'b00} + 32'd4);
      exp_be_q.push_back(be_hi);
      exp_split_q.push_back(1'b0);
      exp_first_q.push_back(1'b0);
      exp_we_q.push_back(we);
    end
    exp_ld_q.push_back(!we);
    exp_err_q.push_back(err_ref(addr, nb));
    if (we) begin
      for (int i = 0; i < nb; i++) begin
        gold[8'(addr + i)] = wdata[8*i +: 8];
      end
      exp_data_q.push_back('0);
    end else begin
      exp_data_q.push_back(load_ref(addr, size, sext));
    end
    ex_valid_i  = 1'b1;
    operand_a_i = addr - b;
    operand_b_i = b;
    wdata_i     = wdata;
    we_i        = we;
    size_i      = size;
    sext_i      = sext;
    do @(posedge clk); while (!ex_ready_o);
  endtask

  task automatic idle();
    @(negedge clk);
    ex_valid_i = 1'b0;
  endtask

  // Wait until the bus is quiet and every expectation is used up
  task automatic drain();
    idle();
    do @(posedge clk); while (busy_o);
    if (exp_addr_q.size() != 0 || exp_ld_q.size() != 0) begin
      fail_stop("traffic drained with expected transfers still pending");
    end
  endtask

  initial begin
    ex_valid_i  = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    wdata_i     = '0;
    we_i        = 1'b0;
    size_i      = SIZE_BYTE;
    sext_i      = 1'b0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = fill_word(i);
    end
    for (int i = 0; i < 256; i++) begin
      gold[i] = fill_word(i / 4) >> (8 * (i % 4));
    end

    // Quiet outputs after reset
    wait (rst_n === 1'b1);
    @(posedge clk);
    check_flag("data_req_o", data_req_o, 1'b0);
    check_flag("wb_valid_o", wb_valid_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("split_o", split_o, 1'b0);
    check_flag("protocol_err_o", protocol_err_o, 1'b0);
    check_flag("interruptible_o", interruptible_o, 1'b1);

    // Aligned word round trip
    run_op(1'b1, SIZE_WORD, 1'b0, 32'h10, 32'hC0DE_1234);
    run_op(1'b0, SIZE_WORD, 1'b0, 32'h10, '0);

    // Bytes and halfwords at every offset, sign bit set
    for (int off = 0; off < 4; off++) begin
      run_op(1'b1, SIZE_BYTE, 1'b0, 32'h20 + off, 32'h80 | (off * 32'h13));
      run_op(1'b0, SIZE_BYTE, 1'b0, 32'h20 + off, '0);
      run_op(1'b0, SIZE_BYTE, 1'b1, 32'h20 + off, '0);
    end
    for (int off = 0; off < 4; off++) begin
      run_op(1'b1, SIZE_HALF, 1'b0, 32'h30 + off, 32'h8000 ^ (off * 32'h1234));
      run_op(1'b0, SIZE_HALF, 1'b0, 32'h30 + off, '0);
      run_op(1'b0, SIZE_HALF, 1'b1, 32'h30 + off, '0);
    end

    // Words that cross into the next word
    for (int off = 1; off < 4; off++) begin
      run_op(1'b1, SIZE_WORD, 1'b0, 32'h50 + off, 32'h8765_4321 ^ off);
      run_op(1'b0, SIZE_WORD, 1'b0, 32'h50 + off, '0);
    end
    drain();

    // Random mix, addresses kept clear of the error word
    for (int n = 0; n < N_RANDOM; n++) begin
      run_op(rand_bits(1), lsu_size_e'(rand_bits(2) % 3), rand_bits(1),
             rand_bits(8) % 248, rand_bits(32));
      if (rand_bits(3) == 0) idle();
    end
    drain();

    // Bus errors on a single access and on either phase of a split
    run_op(1'b0, SIZE_BYTE, 1'b0, 32'hFC, '0);
    run_op(1'b0, SIZE_WORD, 1'b0, 32'hFD, '0);
    run_op(1'b0, SIZE_HALF, 1'b1, 32'hFB, '0);
    drain();

    // Unsolicited response with the bus idle
    stray_pending = 1'b1;
    @(posedge clk);
    check_flag("protocol_err_o", protocol_err_o, 1'b1);
    check_flag("wb_valid_o", wb_valid_o, 1'b0);
    @(posedge clk);
    check_flag("protocol_err_o", protocol_err_o, 1'b0);

    if (dut0.u_props.fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      fail_stop($sformatf("%0d assertion failures seen", dut0.u_props.fail_cnt));
    end
  end

endmodule

`default_nettype wire

/* verif/lsu_properties.sv */
//////////////////////////////
// Bus and execute handshake assertions for the load/store unit
// Attached to every lsu_top instance through bind
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module lsu_properties (
  input wire logic                    clk,
  input wire logic                    rst_n,
  input wire logic                    data_req_i,
  input wire logic                    data_gnt_i,
  input wire lsu_bus_pkg::lsu_word_t  data_addr_i,
  input wire lsu_bus_pkg::lsu_be_t    data_be_i,
  input wire logic                    ex_ready_i,
  input wire logic                    split_i,
  input wire logic                    busy_i
);

  // Number of failed assertions so far
  int unsigned fail_cnt = 0;

  // Stalled request keeps its address and enables until granted
  req_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_i && !data_gnt_i |=> data_req_i && $stable(data_addr_i) && $stable(data_be_i))
  else begin
    $error("bus request changed before its grant");
    fail_cnt++;
  end

  // First half of a split never releases the execute stage
  split_ready_a: assert property (@(posedge clk) disable iff (!rst_n)
    !(ex_ready_i && split_i))
  else begin
    $error("execute ready raised during the first phase of a split");
    fail_cnt++;
  end

  // An open request counts as activity
  req_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_i |-> busy_i)
  else begin
    $error("bus request seen while busy is low");
    fail_cnt++;
  end

endmodule

bind lsu_top lsu_properties u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .data_req_i  (data_req_o),
  .data_gnt_i  (data_gnt_i),
  .data_addr_i (data_addr_o),
  .data_be_i   (data_be_o),
  .ex_ready_i  (ex_ready_o),
  .split_i     (split_o),
  .busy_i      (busy_o)
);

`default_nettype wire

/* verif/tb_clkgen.sv */
//////////////////////////////
// Clock and reset source for the load/store unit testbench
// Reset is held low for a set number of rising edges
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset released on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* logic/lsu_top.sv */
//////////////////////////////
// Load/store unit top level
// Connects the execute stage and writeback to the data bus
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module lsu_top (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  // Execute side
  input  wire logic                    ex_valid_i,
  input  wire lsu_bus_pkg::lsu_word_t  operand_a_i,
  input  wire lsu_bus_pkg::lsu_word_t  operand_b_i,
  input  wire lsu_bus_pkg::lsu_word_t  wdata_i,
  input  wire logic                    we_i,
  input  wire lsu_op_pkg::lsu_size_e   size_i,
  input  wire logic                    sext_i,
  output logic                         ex_ready_o,
  output logic                         split_o,
  output logic                         first_op_o,
  output logic                         last_op_o,
  // Data bus
  output logic                         data_req_o,
  input  wire logic                    data_gnt_i,
  output lsu_bus_pkg::lsu_word_t       data_addr_o,
  output logic                         data_we_o,
  output lsu_bus_pkg::lsu_be_t         data_be_o,
  output lsu_bus_pkg::lsu_word_t       data_wdata_o,
  input  wire logic                    data_rvalid_i,
  input  wire lsu_bus_pkg::lsu_word_t  data_rdata_i,
  input  wire logic                    data_err_i,
  // Writeback
  output logic                         wb_valid_o,
  output lsu_bus_pkg::lsu_word_t       wb_rdata_o,
  output logic                         wb_err_o,
  // Status
  output logic                         busy_o,
  output logic                         interruptible_o,
  output logic                         protocol_err_o
);

  import lsu_bus_pkg::*;

  lsu_word_t   phase_addr;
  lsu_word_t   phase_wdata;
  lsu_be_t     phase_be;
  lsu_offset_t offset;
  logic        split_q;
  logic        ctrl_update;

  ////////////////////////////// Execute phase
  lsu_addr_gen u_addr_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .ex_valid_i    (ex_valid_i),
    .ctrl_update_i (ctrl_update),
    .we_i          (we_i),
    .sext_i        (sext_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .wdata_i       (wdata_i),
    .size_i        (size_i),
    .addr_o        (phase_addr),
    .wdata_o       (phase_wdata),
    .be_o          (phase_be),
    .offset_o      (offset),
    .split_o       (split_o),
    .split_q_o     (split_q)
  );

  ////////////////////////////// Bus control
  lsu_ctrl u_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_valid_i      (ex_valid_i),
    .split_i         (split_o),
    .split_q_i       (split_q),
    .we_i            (we_i),
    .addr_i          (phase_addr),
    .wdata_i         (phase_wdata),
    .be_i            (phase_be),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_req_o      (data_req_o),
    .data_we_o       (data_we_o),
    .data_addr_o     (data_addr_o),
    .data_wdata_o    (data_wdata_o),
    .data_be_o       (data_be_o),
    .ex_ready_o      (ex_ready_o),
    .ctrl_update_o   (ctrl_update),
    .first_op_o      (first_op_o),
    .last_op_o       (last_op_o),
    .busy_o          (busy_o),
    .interruptible_o (interruptible_o),
    .protocol_err_o  (protocol_err_o)
  );

  ////////////////////////////// Writeback phase
  lsu_rdata_align u_rdata_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_update_i (ctrl_update),
    .split_i       (split_o),
    .split_q_i     (split_q),
    .sext_i        (sext_i),
    .we_i          (we_i),
    .size_i        (size_i),
    .offset_i      (offset),
    .data_rvalid_i (data_rvalid_i),
    .data_err_i    (data_err_i),
    .data_rdata_i  (data_rdata_i),
    .wb_valid_o    (wb_valid_o),
    .wb_err_o      (wb_err_o),
    .wb_rdata_o    (wb_rdata_o)
  );

endmodule

`default_nettype wire

/* logic/lsu_rdata_align.sv */
//////////////////////////////
// Writeback phase of the load/store unit
// Queues per-transfer attributes, stitches split loads,
// realigns and extends read data, merges bus errors
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "lsu_params.svh"

module lsu_rdata_align (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     ctrl_update_i,
  input  wire logic                     split_i,
  input  wire logic                     split_q_i,
  input  wire logic                     sext_i,
  input  wire logic                     we_i,
  input  wire lsu_op_pkg::lsu_size_e    size_i,
  input  wire lsu_bus_pkg::lsu_offset_t offset_i,
  input  wire logic                     data_rvalid_i,
  input  wire logic                     data_err_i,
  input  wire lsu_bus_pkg::lsu_word_t   data_rdata_i,
  output logic                          wb_valid_o,
  output logic                          wb_err_o,
  output lsu_bus_pkg::lsu_word_t        wb_rdata_o
);

  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;

  localparam int AW = $clog2(`LSU_DEPTH);

  // One entry per transfer in flight
  lsu_size_e              size_m  [`LSU_DEPTH];
  lsu_offset_t            off_m   [`LSU_DEPTH];
  logic                   sext_m  [`LSU_DEPTH];
  logic                   we_m    [`LSU_DEPTH];
  logic                   first_m [`LSU_DEPTH];
  logic                   last_m  [`LSU_DEPTH];
  logic [AW:0]            wr_ptr_q;
  logic [AW:0]            rd_ptr_q;
  logic [AW-1:0]          rd_idx;
  logic                   resp;
  logic                   err_acc;
  logic                   err_q;
  lsu_word_t              rdata_q;
  logic [2*`LSU_XLEN-1:0] rdata_full;
  logic [2*`LSU_XLEN-1:0] rdata_aligned;

  // Capture attributes as the address phase completes
  always_ff @(posedge clk) begin
    if (ctrl_update_i) begin
      size_m[wr_ptr_q[AW-1:0]]  <= size_i;
      off_m[wr_ptr_q[AW-1:0]]   <= offset_i;
      sext_m[wr_ptr_q[AW-1:0]]  <= sext_i;
      we_m[wr_ptr_q[AW-1:0]]    <= we_i;
      first_m[wr_ptr_q[AW-1:0]] <= !split_q_i;
      last_m[wr_ptr_q[AW-1:0]]  <= !split_i;
    end
  end

  // Extra wrap bit tells full from empty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (ctrl_update_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (resp)          rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  assign rd_idx = rd_ptr_q[AW-1:0];
  // Responses with an empty queue are ignored here
  assign resp   = data_rvalid_i && (wr_ptr_q != rd_ptr_q);

  ////////////////////////////// Errors
  // Second phase folds in the first phase error
  assign err_acc = data_err_i | (!first_m[rd_idx] & err_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else if (resp) begin
      err_q <= last_m[rd_idx] ? 1'b0 : err_acc;
    end
  end

  // Low half of a split load
  always_ff @(posedge clk) begin
    if (resp && !last_m[rd_idx] && !we_m[rd_idx]) begin
      rdata_q <= data_rdata_i;
    end
  end

  ////////////////////////////// Realign and extend
  assign rdata_full    = first_m[rd_idx] ? {data_rdata_i, data_rdata_i}
                                         : {data_rdata_i, rdata_q};
  assign rdata_aligned = rdata_full >> {off_m[rd_idx], 3'b000};

  always_comb begin
    case (size_m[rd_idx])
      SIZE_BYTE: wb_rdata_o = {{24{sext_m[rd_idx] & rdata_aligned[7]}}, rdata_aligned[7:0]};
      SIZE_HALF: wb_rdata_o = {{16{sext_m[rd_idx] & rdata_aligned[15]}}, rdata_aligned[15:0]};
      default:   wb_rdata_o = rdata_aligned[`LSU_XLEN-1:0];
    endcase
  end

  // Writeback only on the last phase
  assign wb_valid_o = resp && last_m[rd_idx];
  assign wb_err_o   = err_acc;

endmodule

`default_nettype wire

/* logic/lsu_ctrl.sv */
//////////////////////////////
// Bus request control of the load/store unit
// Issues requests, counts outstanding transfers and
// drives the execute handshake and status flags
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "lsu_params.svh"

module lsu_ctrl (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    ex_valid_i,
  input  wire logic                    split_i,
  input  wire logic                    split_q_i,
  input  wire logic                    we_i,
  input  wire lsu_bus_pkg::lsu_word_t  addr_i,
  input  wire lsu_bus_pkg::lsu_word_t  wdata_i,
  input  wire lsu_bus_pkg::lsu_be_t    be_i,
  input  wire logic                    data_gnt_i,
  input  wire logic                    data_rvalid_i,
  output logic                         data_req_o,
  output logic                         data_we_o,
  output lsu_bus_pkg::lsu_word_t       data_addr_o,
  output lsu_bus_pkg::lsu_word_t       data_wdata_o,
  output lsu_bus_pkg::lsu_be_t         data_be_o,
  output logic                         ex_ready_o,
  output logic                         ctrl_update_o,
  output logic                         first_op_o,
  output logic                         last_op_o,
  output logic                         busy_o,
  output logic                         interruptible_o,
  output logic                         protocol_err_o
);

  logic [`LSU_CNT_W-1:0] cnt_q;
  logic [`LSU_CNT_W-1:0] cnt_d;
  logic                  count_up;
  logic                  count_down;
  logic                  done;
  logic                  req_wait_q;

  ////////////////////////////// Request issue
  // Hold off while the bus already has the max in flight
  assign data_req_o   = ex_valid_i && (cnt_q < `LSU_CNT_W'(`LSU_DEPTH));
  assign data_we_o    = we_i;
  assign data_addr_o  = addr_i;
  assign data_wdata_o = wdata_i;
  assign data_be_o    = be_i;

  // Phase done on grant, or trivially with nothing to do
  assign done          = !ex_valid_i || (data_req_o && data_gnt_i);
  assign ctrl_update_o = ex_valid_i && data_req_o && data_gnt_i;
  // First half of a split keeps the op in execute
  assign ex_ready_o    = done && !split_i;
  assign first_op_o    = !split_q_i;
  assign last_op_o     = !split_i;

  ////////////////////////////// Outstanding counter
  assign count_up   = data_req_o && data_gnt_i;
  // A stray response must not wrap the count
  assign count_down = data_rvalid_i && (cnt_q != '0);

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Request seen without grant, it may not be retracted now
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_wait_q <= 1'b0;
    end else if (ctrl_update_o) begin
      req_wait_q <= 1'b0;
    end else if (data_req_o) begin
      req_wait_q <= 1'b1;
    end
  end

  ////////////////////////////// Status
  assign busy_o          = (cnt_q != '0) || data_req_o;
  assign interruptible_o = !req_wait_q && (cnt_q == '0);
  // Response with nothing in flight
  assign protocol_err_o  = data_rvalid_i && (cnt_q == '0);

endmodule

`default_nettype wire

/* logic/lsu_addr_gen.sv */
//////////////////////////////
// Execute phase of the load/store unit
// Forms the address, byte enables and rotated store data,
// and tracks the second phase of a split access
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "lsu_params.svh"

module lsu_addr_gen (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    ex_valid_i,
  input  wire logic                    ctrl_update_i,
  input  wire logic                    we_i,
  input  wire logic                    sext_i,
  input  wire lsu_bus_pkg::lsu_word_t  operand_a_i,
  input  wire lsu_bus_pkg::lsu_word_t  operand_b_i,
  input  wire lsu_bus_pkg::lsu_word_t  wdata_i,
  input  wire lsu_op_pkg::lsu_size_e   size_i,
  output lsu_bus_pkg::lsu_word_t       addr_o,
  output lsu_bus_pkg::lsu_word_t       wdata_o,
  output lsu_bus_pkg::lsu_be_t         be_o,
  output lsu_bus_pkg::lsu_offset_t     offset_o,
  output logic                         split_o,
  output logic                         split_q_o
);

  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;

  lsu_word_t                      addr;
  lsu_offset_t                    offset;
  logic [2*`LSU_NBYTES-1:0]       be_span;
  lsu_word_t                      wdata_ext;
  lsu_word_t                      wdata_sel;
  logic [2*`LSU_XLEN-1:0]         wdata_dbl;
  logic                           split_q;

  // Effective address
  assign addr   = operand_a_i + operand_b_i;
  assign offset = addr[$clog2(`LSU_NBYTES)-1:0];

  // Second phase goes to the next aligned word
  assign addr_o   = split_q ? {addr[`LSU_XLEN-1:2], 2'b00} + lsu_word_t'(`LSU_NBYTES) : addr;
  assign offset_o = offset;

  ////////////////////////////// Byte enables
  // Size mask moved up by the offset, upper half spills into the next word
  assign be_span = {{`LSU_NBYTES{1'b0}}, lsu_size_mask(size_i)} << offset;
  // Low half on the first phase, missing low lanes on the second
  assign be_o    = split_q ? be_span[2*`LSU_NBYTES-1:`LSU_NBYTES] : be_span[`LSU_NBYTES-1:0];

  ////////////////////////////// Store data
  // Narrow store data is widened like a load result
  always_comb begin
    case (size_i)
      SIZE_BYTE: wdata_ext = {{24{sext_i & wdata_i[7]}}, wdata_i[7:0]};
      SIZE_HALF: wdata_ext = {{16{sext_i & wdata_i[15]}}, wdata_i[15:0]};
      default:   wdata_ext = wdata_i;
    endcase
  end

  // Loads keep the data bus quiet
  assign wdata_sel = we_i ? wdata_ext : '0;

  // Rotate left by the offset in bytes
  assign wdata_dbl = {wdata_sel, wdata_sel} << {offset, 3'b000};
  assign wdata_o   = wdata_dbl[2*`LSU_XLEN-1:`LSU_XLEN];

  ////////////////////////////// Split tracking
  // Word off alignment or halfword at the last lane needs two transfers
  always_comb begin
    split_o = 1'b0;
    if (ex_valid_i && !split_q) begin
      case (size_i)
        SIZE_WORD: split_o = (offset != '0);
        SIZE_HALF: split_o = (&offset);
        default:   split_o = 1'b0;
      endcase
    end
  end

  // Second phase active, dropped as soon as the op goes away
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!ex_valid_i) begin
      split_q <= 1'b0;
    end else if (ctrl_update_i) begin
      split_q <= split_o;
    end
  end

  assign split_q_o = split_q;

endmodule

`default_nettype wire

/* logic/lsu_bus_pkg.sv */
//////////////////////////////
// Data bus field types for the load/store unit
// Address, data, byte enables and lane offset within a word
//////////////////////////////

`default_nettype none

`include "lsu_params.svh"

package lsu_bus_pkg;

  // Address or data word
  typedef logic [`LSU_XLEN-1:0] lsu_word_t;

  // One enable per byte lane
  typedef logic [`LSU_NBYTES-1:0] lsu_be_t;

  // Byte offset inside a word
  typedef logic [$clog2(`LSU_NBYTES)-1:0] lsu_offset_t;

endpackage

`default_nettype wire

/* logic/lsu_op_pkg.sv */
//////////////////////////////
// Execute-side operation types for the load/store unit
// Access size encoding and the lane mask that goes with each size
//////////////////////////////

`default_nettype none

`include "lsu_params.svh"

package lsu_op_pkg;

  // Access size as driven by the decoder
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lsu_size_e;

  // Lanes touched by an access at offset zero
  function automatic logic [`LSU_NBYTES-1:0] lsu_size_mask(lsu_size_e size);
    case (size)
      SIZE_BYTE: return `LSU_NBYTES'('b0001);
      SIZE_HALF: return `LSU_NBYTES'('b0011);
      default:   return {`LSU_NBYTES{1'b1}};
    endcase
  endfunction

endpackage

`default_nettype wire

/* logic/lsu_params.svh */
//////////////////////////////
// Sizing macros shared by the load/store unit packages and RTL
// Include wherever a width or the outstanding depth is needed
//////////////////////////////

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Data and address width
`define LSU_XLEN 32
// Max bus transfers in flight
`define LSU_DEPTH 2
// Outstanding counter width, holds 0..LSU_DEPTH
`define LSU_CNT_W 2
// Byte lanes per data word
`define LSU_NBYTES 4

`endif
